// ==== design/wheel_pkg.sv ====
// Wheel speed controller shared definitions
// Widths, Q8.8 conversion constants, timing constants and enums

package wheel_pkg;

	// ==================================================
	// Widths
	// ==================================================
	localparam int N_WIDTH    = 17;             // Sign bit + Q8.8 magnitude
	localparam int Q_WIDTH    = 8;              // Fraction bits
	localparam int MAG_WIDTH  = N_WIDTH - 1;    // Q8.8 magnitude only
	localparam int CNT_WIDTH  = 8;              // Pulses per window
	localparam int DUTY_WIDTH = 8;              // PWM duty
	localparam int GAIN_WIDTH = 8;              // PI gains, Q4.4
	localparam int GAIN_FRAC  = 4;              // Fraction bits of the gains
	localparam int ACC_WIDTH  = 32;             // PI arithmetic, signed

	// ==================================================
	// Fixed-point constants, Q8.8
	// ==================================================
	localparam logic [MAG_WIDTH-1:0] RPM_PER_PULSE = 16'h04C5; // 4.7695
	localparam logic [MAG_WIDTH-1:0] RPM_PER_RAD   = 16'h098C; // 9.5469
	localparam logic [MAG_WIDTH-1:0] RAD_PER_RPM   = 16'h001B; // 0.1055

	localparam int INT_LIMIT = 2 ** 20;         // Integrator clamp, +/-

	// ==================================================
	// Timing
	// ==================================================
	localparam int SAMPLE_CYCLES = 4096;        // Short window for simulation
	localparam int WIN_WIDTH     = $clog2(SAMPLE_CYCLES);
	localparam int PWM_PRESCALE  = 4;           // Clocks per PWM step
	localparam int PRE_WIDTH     = $clog2(PWM_PRESCALE);

	// Wishbone word addresses
	typedef enum logic [2:0] {
		REG_TARGET = 3'd0,  // RW, sign-magnitude Q8.8 rad/s
		REG_KP     = 3'd1,  // RW, Q4.4
		REG_KI     = 3'd2,  // RW, Q4.4
		REG_RPM    = 3'd3,  // RO, measured rpm
		REG_W      = 3'd4,  // RO, measured rad/s
		REG_STATUS = 3'd5   // RO, duty / dir / sample count
	} wb_reg_e;

	// H-bridge drive code
	typedef enum logic [1:0] {
		DIR_BRAKE = 2'b00,
		DIR_FWD   = 2'b01,
		DIR_REV   = 2'b10
	} drive_dir_e;

endpackage

// ==== design/wb_wheel_regs.sv ====
// Wheel controller bus registers
// Wishbone classic slave for setpoint and PI gains, plus speed/status read-back

`timescale 1ns/10ps

module wb_wheel_regs (
	input  logic                                  i_clock_50,
	input  logic                                  i_rst_n,
	input  logic                                  i_wb_cyc,
	input  logic                                  i_wb_stb,
	input  logic                                  i_wb_we,
	input  logic [2:0]                            i_wb_adr,     // Word address
	input  logic [31:0]                           i_wb_dat,
	output logic [31:0]                           o_wb_dat,
	output logic                                  o_wb_ack,
	output logic [wheel_pkg::N_WIDTH-1:0]         o_target_w,
	output logic [wheel_pkg::GAIN_WIDTH-1:0]      o_kp,
	output logic [wheel_pkg::GAIN_WIDTH-1:0]      o_ki,
	input  logic [wheel_pkg::N_WIDTH-1:0]         i_rpm_meas,
	input  logic [wheel_pkg::N_WIDTH-1:0]         i_w_meas,
	input  logic [wheel_pkg::DUTY_WIDTH-1:0]      i_duty,
	input  logic                                  i_meas_dir,
	input  logic                                  i_exec_valid
);

	logic                                 bus_req;     // New access, ack not yet given
	logic [wheel_pkg::N_WIDTH-1:0]        rpm_q;
	logic [wheel_pkg::N_WIDTH-1:0]        w_q;
	logic [wheel_pkg::DUTY_WIDTH-1:0]     duty_q;
	logic                                 dir_q;
	logic [7:0]                           samples_q;   // Completed samples, wraps at 256
	logic [31:0]                          rd_data;

	assign bus_req = i_wb_cyc && i_wb_stb && !o_wb_ack;

	// ==================================================
	// Bus handshake and writable registers
	// ==================================================
	always_ff @(posedge i_clock_50) begin
		if (!i_rst_n) begin
			o_wb_ack   <= 1'b0;
			o_wb_dat   <= '0;
			o_target_w <= '0;
			o_kp       <= '0;
			o_ki       <= '0;
		end else begin
			o_wb_ack <= bus_req;                       // Single-cycle ack
			if (bus_req) begin
				o_wb_dat <= rd_data;                   // Valid while ack is high
			end
			// Write lands on the acknowledging edge
			if (bus_req && i_wb_we) begin
				case (wheel_pkg::wb_reg_e'(i_wb_adr))
					wheel_pkg::REG_TARGET: o_target_w <= i_wb_dat[wheel_pkg::N_WIDTH-1:0];
					wheel_pkg::REG_KP:     o_kp       <= i_wb_dat[wheel_pkg::GAIN_WIDTH-1:0];
					wheel_pkg::REG_KI:     o_ki       <= i_wb_dat[wheel_pkg::GAIN_WIDTH-1:0];
					default: ;                         // Read-only, acked and dropped
				endcase
			end
		end
	end

	// Status capture once per executed sample
	always_ff @(posedge i_clock_50) begin
		if (!i_rst_n) begin
			rpm_q     <= '0;
			w_q       <= '0;
			duty_q    <= '0;
			dir_q     <= 1'b0;
			samples_q <= '0;
		end else if (i_exec_valid) begin
			rpm_q     <= i_rpm_meas;
			w_q       <= i_w_meas;
			duty_q    <= i_duty;
			dir_q     <= i_meas_dir;
			samples_q <= samples_q + 8'd1;
		end
	end

	// ==================================================
	// Read mux
	// ==================================================
	always_comb begin
		case (wheel_pkg::wb_reg_e'(i_wb_adr))
			wheel_pkg::REG_TARGET: rd_data = 32'(o_target_w);
			wheel_pkg::REG_KP:     rd_data = 32'(o_kp);
			wheel_pkg::REG_KI:     rd_data = 32'(o_ki);
			wheel_pkg::REG_RPM:    rd_data = 32'(rpm_q);
			wheel_pkg::REG_W:      rd_data = 32'(w_q);
			wheel_pkg::REG_STATUS: rd_data = {8'd0, samples_q, 7'd0, dir_q, duty_q};
			default:               rd_data = '0;  // Unmapped words read zero
		endcase
	end

	// Master must drop stb or see a gap, never a back-to-back ack
	a_ack_single : assert property (@(posedge i_clock_50) disable iff (!i_rst_n)
		o_wb_ack |=> !o_wb_ack)
		else $error("[ERROR] %0t wb ack held two clocks", $time);

endmodule

// ==== design/quad_decode.sv ====
// Quadrature decode stage
// Synchronizes A/B, counts every edge over a fixed window, reports direction

`timescale 1ns/10ps

module quad_decode (
	input  logic                               i_clock_50,
	input  logic                               i_rst_n,
	input  logic                               i_enc_a,
	input  logic                               i_enc_b,
	output logic                               o_sample_stb,   // One clock at window end
	output logic [wheel_pkg::CNT_WIDTH-1:0]    o_pulse_count,  // Saturated at 255
	output logic                               o_meas_dir      // 0 cw, 1 ccw
);

	logic                                a_meta, a_sync, a_last;
	logic                                b_meta, b_sync, b_last;
	logic                                a_edge, b_edge, any_edge;
	logic                                dir_live;
	logic [wheel_pkg::CNT_WIDTH-1:0]     acc;
	logic [wheel_pkg::CNT_WIDTH-1:0]     acc_inc;
	logic [wheel_pkg::WIN_WIDTH-1:0]     win_cnt;
	logic                                win_end;

	// ==================================================
	// Synchronizer and edge detect
	// ==================================================
	always_ff @(posedge i_clock_50) begin
		if (!i_rst_n) begin
			a_meta <= 1'b0;
			a_sync <= 1'b0;
			a_last <= 1'b0;
			b_meta <= 1'b0;
			b_sync <= 1'b0;
			b_last <= 1'b0;
		end else begin
			a_meta <= i_enc_a;   // Two-flop sync
			a_sync <= a_meta;
			a_last <= a_sync;    // Previous sample for edges
			b_meta <= i_enc_b;
			b_sync <= b_meta;
			b_last <= b_sync;
		end
	end

	assign a_edge   = a_sync ^ a_last;
	assign b_edge   = b_sync ^ b_last;
	assign any_edge = a_edge || b_edge;   // x4 decoding

	// A leading B gives old A == new B on every step, call that clockwise
	always_ff @(posedge i_clock_50) begin
		if (!i_rst_n) begin
			dir_live <= 1'b0;
		end else if (any_edge) begin
			dir_live <= a_last ^ b_sync;
		end
	end

	// ==================================================
	// Sample window and edge accumulator
	// ==================================================
	assign win_end = (win_cnt == wheel_pkg::WIN_WIDTH'(wheel_pkg::SAMPLE_CYCLES - 1));
	assign acc_inc = (any_edge && acc != '1) ? acc + 1'b1 : acc;  // Sticks at full scale

	always_ff @(posedge i_clock_50) begin
		if (!i_rst_n) begin
			win_cnt       <= '0;
			acc           <= '0;
			o_sample_stb  <= 1'b0;
			o_pulse_count <= '0;
			o_meas_dir    <= 1'b0;
		end else begin
			win_cnt      <= win_end ? '0 : win_cnt + 1'b1;
			o_sample_stb <= win_end;
			if (win_end) begin
				o_pulse_count <= acc_inc;  // Last-cycle edge still counts here
				o_meas_dir    <= dir_live;
				acc           <= '0;
			end else begin
				acc <= acc_inc;
			end
		end
	end

	// Gray sequence only, a double change means lost steps or noise
	a_gray_step : assert property (@(posedge i_clock_50) disable iff (!i_rst_n)
		!(a_edge && b_edge))
		else $error("[ERROR] %0t encoder A and B changed together", $time);

endmodule

// ==== design/speed_pi_exec.sv ====
// Speed execute stage
// Two-stage Q8.8 pipeline: rpm conversions and error, then saturating PI
// update and rad/s read-back

`timescale 1ns/10ps

module speed_pi_exec (
	input  logic                                  i_clock_50,
	input  logic                                  i_rst_n,
	input  logic                                  i_sample_stb,
	input  logic [wheel_pkg::CNT_WIDTH-1:0]       i_pulse_count,
	input  logic [wheel_pkg::N_WIDTH-1:0]         i_target_w,    // Sign-magnitude rad/s
	input  logic [wheel_pkg::GAIN_WIDTH-1:0]      i_kp,          // Q4.4
	input  logic [wheel_pkg::GAIN_WIDTH-1:0]      i_ki,          // Q4.4
	output logic                                  o_exec_valid,
	output logic [wheel_pkg::N_WIDTH-1:0]         o_rpm_meas,
	output logic [wheel_pkg::N_WIDTH-1:0]         o_w_meas,
	output logic [wheel_pkg::DUTY_WIDTH-1:0]      o_duty
);

	localparam int MW = wheel_pkg::MAG_WIDTH;
	localparam int QW = wheel_pkg::Q_WIDTH;
	localparam int AW = wheel_pkg::ACC_WIDTH;

	// Stage 1 signals
	logic [2*MW-1:0]          rpm_prod, sp_prod;
	logic [MW-1:0]            rpm_d, sp_d;
	logic signed [MW+1:0]     err_d;
	logic                     valid_s1;
	logic [MW-1:0]            rpm_s1;
	logic signed [MW+1:0]     err_s1;         // Setpoint minus measured, Q8.8
	logic                     sign_s1;

	// Stage 2 signals
	logic signed [AW-1:0]     kp_prod, ki_prod;
	logic signed [AW-1:0]     kp_term, ki_term;
	logic signed [AW-1:0]     integ, integ_sum, integ_sat;
	logic signed [AW-1:0]     pi_sum, duty_int;
	logic [wheel_pkg::DUTY_WIDTH-1:0] duty_sat;
	logic [2*MW-1:0]          w_prod;

	// ==================================================
	// Stage 1, unit conversion and error
	// ==================================================
	// Integer count lifted to Q8.8, then product back to Q8.8 by dropping 8 bits
	assign rpm_prod = {i_pulse_count, {QW{1'b0}}} * wheel_pkg::RPM_PER_PULSE;
	assign rpm_d    = rpm_prod[MW+QW-1:QW];  // Integer overflow wraps
	assign sp_prod  = i_target_w[MW-1:0] * wheel_pkg::RPM_PER_RAD;
	assign sp_d     = sp_prod[MW+QW-1:QW];   // Setpoint magnitude only
	assign err_d    = $signed({2'b00, sp_d}) - $signed({2'b00, rpm_d});

	always_ff @(posedge i_clock_50) begin
		if (!i_rst_n) begin
			valid_s1 <= 1'b0;
		end else begin
			valid_s1 <= i_sample_stb;
		end
	end

	always_ff @(posedge i_clock_50) begin
		if (i_sample_stb) begin
			rpm_s1  <= rpm_d;
			err_s1  <= err_d;
			sign_s1 <= i_target_w[wheel_pkg::N_WIDTH-1];  // Drives w_meas sign
		end
	end

	// ==================================================
	// Stage 2, PI update
	// ==================================================
	// Q4.4 gain times Q8.8 error, scaled back to Q8.8
	assign kp_prod = $signed({1'b0, i_kp}) * err_s1;
	assign ki_prod = $signed({1'b0, i_ki}) * err_s1;
	assign kp_term = kp_prod >>> wheel_pkg::GAIN_FRAC;
	assign ki_term = ki_prod >>> wheel_pkg::GAIN_FRAC;
	assign integ_sum = integ + ki_term;

	always_comb begin
		// Windup limited by clamp only
		if (integ_sum > wheel_pkg::INT_LIMIT) begin
			integ_sat = AW'(wheel_pkg::INT_LIMIT);
		end else if (integ_sum < -wheel_pkg::INT_LIMIT) begin
			integ_sat = AW'(-wheel_pkg::INT_LIMIT);
		end else begin
			integ_sat = integ_sum;
		end
	end

	assign pi_sum   = kp_term + integ_sat;   // Uses the freshly updated integrator
	assign duty_int = pi_sum >>> QW;         // Integer part

	always_comb begin
		if (duty_int < 0) begin
			duty_sat = '0;
		end else if (|duty_int[AW-1:wheel_pkg::DUTY_WIDTH]) begin
			duty_sat = '1;                   // Full on
		end else begin
			duty_sat = duty_int[wheel_pkg::DUTY_WIDTH-1:0];
		end
	end

	assign w_prod = rpm_s1 * wheel_pkg::RAD_PER_RPM;  // Back to rad/s

	always_ff @(posedge i_clock_50) begin
		if (!i_rst_n) begin
			o_exec_valid <= 1'b0;
			integ        <= '0;
			o_duty       <= '0;
		end else begin
			o_exec_valid <= valid_s1;
			if (valid_s1) begin
				integ  <= integ_sat;
				o_duty <= duty_sat;
			end
		end
	end

	always_ff @(posedge i_clock_50) begin
		if (valid_s1) begin
			o_rpm_meas <= {1'b0, rpm_s1};                 // Always positive
			o_w_meas   <= {sign_s1, w_prod[MW+QW-1:QW]};  // Sign from setpoint
		end
	end

	// Fixed two-clock latency from window end to result
	a_exec_latency : assert property (@(posedge i_clock_50) disable iff (!i_rst_n)
		o_exec_valid == $past(i_sample_stb, 2))
		else $error("[ERROR] %0t exec_valid not sample_stb + 2", $time);

endmodule

// ==== design/pwm_result.sv ====
// PWM result stage
// Prescaled 8-bit PWM with duty update at period wrap, H-bridge direction decode

`timescale 1ns/10ps

module pwm_result (
	input  logic                                i_clock_50,
	input  logic                                i_rst_n,
	input  logic [wheel_pkg::DUTY_WIDTH-1:0]    i_duty,
	input  logic                                i_exec_valid,
	input  logic [wheel_pkg::N_WIDTH-1:0]       i_target_w,
	output logic                                o_pwm,
	output wheel_pkg::drive_dir_e               o_dir
);

	logic [wheel_pkg::PRE_WIDTH-1:0]     pre_cnt;
	logic [wheel_pkg::DUTY_WIDTH-1:0]    pwm_cnt;
	logic [wheel_pkg::DUTY_WIDTH-1:0]    duty_pending;  // Waits for next period
	logic [wheel_pkg::DUTY_WIDTH-1:0]    duty_active;
	logic                                step, wrap;

	assign step = (pre_cnt == wheel_pkg::PRE_WIDTH'(wheel_pkg::PWM_PRESCALE - 1));
	assign wrap = step && (pwm_cnt == '1);   // End of a 256-step period

	// ==================================================
	// Period counter and duty handover
	// ==================================================
	always_ff @(posedge i_clock_50) begin
		if (!i_rst_n) begin
			pre_cnt      <= '0;
			pwm_cnt      <= '0;
			duty_pending <= '0;
			duty_active  <= '0;
			o_pwm        <= 1'b0;
		end else begin
			pre_cnt <= step ? '0 : pre_cnt + 1'b1;
			if (step) begin
				pwm_cnt <= pwm_cnt + 1'b1;  // Rolls over at wrap
			end
			if (i_exec_valid) begin
				duty_pending <= i_duty;
			end
			if (wrap) begin
				duty_active <= duty_pending;
			end
			// Registered compare, high for duty * PWM_PRESCALE clocks
			o_pwm <= (pwm_cnt < duty_active);
		end
	end

	// Direction straight from setpoint sign, zero magnitude brakes
	always_comb begin
		if (i_target_w[wheel_pkg::MAG_WIDTH-1:0] == '0) begin
			o_dir = wheel_pkg::DIR_BRAKE;
		end else if (i_target_w[wheel_pkg::N_WIDTH-1]) begin
			o_dir = wheel_pkg::DIR_REV;
		end else begin
			o_dir = wheel_pkg::DIR_FWD;
		end
	end

endmodule

// ==== design/wheel_controller.sv ====
// Wheel speed controller top level
// Wishbone registers feeding decode, PI execute and PWM result stages

`timescale 1ns/10ps

module wheel_controller (
	input  logic                    i_clock_50,
	input  logic                    i_rst_n,
	// Wishbone classic slave
	input  logic                    i_wb_cyc,
	input  logic                    i_wb_stb,
	input  logic                    i_wb_we,
	input  logic [2:0]              i_wb_adr,
	input  logic [31:0]             i_wb_dat,
	output logic [31:0]             o_wb_dat,
	output logic                    o_wb_ack,
	// Encoder and H-bridge
	input  logic                    i_enc_a,
	input  logic                    i_enc_b,
	output logic                    o_pwm,
	output wheel_pkg::drive_dir_e   o_dir
);

	// ==================================================
	// Inter-stage wires
	// ==================================================
	logic [wheel_pkg::N_WIDTH-1:0]       target_w;
	logic [wheel_pkg::GAIN_WIDTH-1:0]    kp;
	logic [wheel_pkg::GAIN_WIDTH-1:0]    ki;
	logic                                sample_stb;
	logic [wheel_pkg::CNT_WIDTH-1:0]     pulse_count;
	logic                                meas_dir;
	logic                                exec_valid;
	logic [wheel_pkg::N_WIDTH-1:0]       rpm_meas;
	logic [wheel_pkg::N_WIDTH-1:0]       w_meas;
	logic [wheel_pkg::DUTY_WIDTH-1:0]    duty;

	wb_wheel_regs u_regs (
		.i_clock_50   (i_clock_50),
		.i_rst_n      (i_rst_n),
		.i_wb_cyc     (i_wb_cyc),
		.i_wb_stb     (i_wb_stb),
		.i_wb_we      (i_wb_we),
		.i_wb_adr     (i_wb_adr),
		.i_wb_dat     (i_wb_dat),
		.o_wb_dat     (o_wb_dat),
		.o_wb_ack     (o_wb_ack),
		.o_target_w   (target_w),
		.o_kp         (kp),
		.o_ki         (ki),
		.i_rpm_meas   (rpm_meas),
		.i_w_meas     (w_meas),
		.i_duty       (duty),
		.i_meas_dir   (meas_dir),
		.i_exec_valid (exec_valid)
	);

	// Decode stage
	quad_decode u_decode (
		.i_clock_50    (i_clock_50),
		.i_rst_n       (i_rst_n),
		.i_enc_a       (i_enc_a),
		.i_enc_b       (i_enc_b),
		.o_sample_stb  (sample_stb),
		.o_pulse_count (pulse_count),
		.o_meas_dir    (meas_dir)
	);

	// Execute stage
	speed_pi_exec u_exec (
		.i_clock_50    (i_clock_50),
		.i_rst_n       (i_rst_n),
		.i_sample_stb  (sample_stb),
		.i_pulse_count (pulse_count),
		.i_target_w    (target_w),
		.i_kp          (kp),
		.i_ki          (ki),
		.o_exec_valid  (exec_valid),
		.o_rpm_meas    (rpm_meas),
		.o_w_meas      (w_meas),
		.o_duty        (duty)
	);

	// Result stage
	pwm_result u_result (
		.i_clock_50   (i_clock_50),
		.i_rst_n      (i_rst_n),
		.i_duty       (duty),
		.i_exec_valid (exec_valid),
		.i_target_w   (target_w),
		.o_pwm        (o_pwm),
		.o_dir        (o_dir)
	);

endmodule

// ==== tb/tb_wheel_controller.sv ====
// Wheel speed controller testbench
// Drives the Wishbone bus and the encoder from golden vectors and checks
// measured speed, PI duty, direction and PWM against the expected columns

`timescale 1ns/10ps

module tb_wheel_controller;

	localparam int PWM_PERIOD = 256 * wheel_pkg::PWM_PRESCALE;  // Clocks per PWM period
	localparam int ACK_LIMIT  = 16;                             // Clocks to wait for ack
	localparam int POLL_LIMIT = 3000;                           // Status polls per window
	localparam logic [31:0] TARGET_MASK = (32'd1 << wheel_pkg::N_WIDTH) - 1;
	localparam logic [31:0] GAIN_MASK   = (32'd1 << wheel_pkg::GAIN_WIDTH) - 1;

	logic                    clock_50;
	logic                    rst_n;
	logic                    wb_cyc;
	logic                    wb_stb;
	logic                    wb_we;
	logic [2:0]              wb_adr;
	logic [31:0]             wb_dat_w;
	logic [31:0]             wb_dat_r;
	logic                    wb_ack;
	logic                    enc_a;
	logic                    enc_b;
	logic                    pwm;
	wheel_pkg::drive_dir_e   dir_out;

	logic [1:0]              enc_phase;   // Position in the Gray cycle 00,10,11,01
	logic [7:0]              sample_cnt;  // Last seen sample count from status
	int                      err_total;
	int                      tests_run;
	int                      tests_failed;
	int                      seed_val;

	wheel_controller u_wheel_controller (
		.i_clock_50 (clock_50),
		.i_rst_n    (rst_n),
		.i_wb_cyc   (wb_cyc),
		.i_wb_stb   (wb_stb),
		.i_wb_we    (wb_we),
		.i_wb_adr   (wb_adr),
		.i_wb_dat   (wb_dat_w),
		.o_wb_dat   (wb_dat_r),
		.o_wb_ack   (wb_ack),
		.i_enc_a    (enc_a),
		.i_enc_b    (enc_b),
		.o_pwm      (pwm),
		.o_dir      (dir_out)
	);

	initial begin
		clock_50 = 1'b0;
		forever #20 clock_50 = ~clock_50;  // 40 ns period
	end

	// ==================================================
	// Reporting
	// ==================================================
	task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
			err_total++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (err_total != errs_before) begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, err_total - errs_before);
		end else begin
			$display("%s: ok", name);
		end
	endtask

	task automatic finish_run();
		$display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, err_total);
		if (err_total == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		err_total++;
		finish_run();
	endtask

	// ==================================================
	// Wishbone master, one access at a time
	// ==================================================
	task automatic bus_access(input logic we, input logic [2:0] adr, input logic [31:0] wdata,
	                          output logic [31:0] rdata);
		int waited;
		waited = 0;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdata;
		@(negedge clock_50);
		while (!wb_ack && waited < ACK_LIMIT) begin
			@(negedge clock_50);
			waited++;
		end
		if (!wb_ack) begin
			abort_run("Bus access got no ack from the DUT in time");
		end else begin
			rdata  = wb_dat_r;  // Read data valid with ack
			wb_cyc = 1'b0;
			wb_stb = 1'b0;
			wb_we  = 1'b0;
			@(negedge clock_50);
			assert (!wb_ack) else begin
				$display("[ERROR] %0t ack held for more than one clock", $time);
				err_total++;
			end
		end
	endtask

	task automatic wb_write(input logic [2:0] adr, input logic [31:0] wdata);
		logic [31:0] unused;
		bus_access(1'b1, adr, wdata, unused);
	endtask

	task automatic wb_read(input logic [2:0] adr, output logic [31:0] rdata);
		bus_access(1'b0, adr, 32'd0, rdata);
	endtask

	// Polls status until the sample count moves on by one window
	task automatic wait_sample();
		logic [31:0] status;
		int          polls;
		logic        seen;
		polls = 0;
		seen  = 1'b0;
		while (!seen && polls < POLL_LIMIT) begin
			wb_read(wheel_pkg::REG_STATUS, status);
			polls++;
			if (status[23:16] != sample_cnt) begin
				seen = 1'b1;
				check_eq("sample count step", 32'(status[23:16]), 32'(sample_cnt + 8'd1));
				sample_cnt = status[23:16];
			end
		end
		if (!seen) begin
			abort_run("Sample count never advanced, window end not seen");
		end
	endtask

	// ==================================================
	// Encoder and PWM
	// ==================================================
	task automatic drive_edges(input int count, input logic ccw);
		int gap;
		int e;
		for (e = 0; e < count; e++) begin
			gap = $urandom_range(12, 2);        // At least two clocks per step
			repeat (gap) @(negedge clock_50);
			enc_phase = ccw ? enc_phase - 2'd1 : enc_phase + 2'd1;
			enc_a     = enc_phase[1] ^ enc_phase[0];
			enc_b     = enc_phase[1];
		end
	endtask

	task automatic pwm_check(input logic [7:0] duty);
		int   waited;
		int   high_clks;
		logic prev;
		logic rose;
		waited    = 0;
		high_clks = 0;
		rose      = 1'b0;
		if (duty == 8'd0) begin
			repeat (PWM_PERIOD + 8) @(negedge clock_50);  // Let an old period drain
			repeat (PWM_PERIOD) begin
				@(negedge clock_50);
				if (pwm) high_clks++;
			end
			check_eq("PWM high clocks at zero duty", high_clks, 0);
		end else begin
			prev = pwm;                                  // A pulse in progress is skipped
			while (!rose && waited < 2 * PWM_PERIOD + 8) begin
				@(negedge clock_50);
				rose = !prev && pwm;
				prev = pwm;
				waited++;
			end
			if (!rose) begin
				abort_run("PWM output never rose after the duty update");
			end else begin
				waited = 0;
				while (pwm && waited < PWM_PERIOD + 8) begin
					high_clks++;
					@(negedge clock_50);
					waited++;
				end
				if (pwm) begin
					abort_run("PWM output never fell within one period");
				end else begin
					check_eq("PWM high clocks", high_clks,
					         int'(duty) * wheel_pkg::PWM_PRESCALE);
				end
			end
		end
	endtask

	// One golden line: idle window with new settings, then a window of edges
	task automatic run_vector(input int idx, input logic [31:0] target, input logic [31:0] kp,
	                          input logic [31:0] ki, input logic [31:0] edges,
	                          input logic [31:0] dir, input logic [31:0] exp_rpm,
	                          input logic [31:0] exp_w, input logic [31:0] exp_duty,
	                          input logic [31:0] exp_odir);
		int          errs_before;
		logic [31:0] rd;
		errs_before = err_total;
		wb_write(wheel_pkg::REG_TARGET, target);
		wb_write(wheel_pkg::REG_KP, kp);
		wb_write(wheel_pkg::REG_KI, ki);
		check_eq("o_dir", 32'(dir_out), exp_odir);
		wait_sample();                      // Window starts here
		drive_edges(int'(edges), dir[0]);
		wait_sample();                      // Result of the edge window
		wb_read(wheel_pkg::REG_RPM, rd);
		check_eq("REG_RPM", rd, exp_rpm);
		wb_read(wheel_pkg::REG_W, rd);
		check_eq("REG_W", rd, exp_w);
		wb_read(wheel_pkg::REG_STATUS, rd);
		check_eq("status duty", 32'(rd[7:0]), exp_duty);
		check_eq("status measured dir", 32'(rd[8]), 32'(dir[0]));
		pwm_check(exp_duty[7:0]);
		report_test($sformatf("vector %0d", idx), errs_before);
	endtask

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		int          fd;
		int          n_read;
		int          vec_idx;
		int          errs_before;
		int          a;
		string       line;
		logic [31:0] rd;
		logic [31:0] f_target, f_kp, f_ki, f_edges, f_dir;
		logic [31:0] f_rpm, f_w, f_duty, f_odir;

		err_total    = 0;
		tests_run    = 0;
		tests_failed = 0;
		sample_cnt   = 8'd0;
		enc_phase    = 2'd0;
		rst_n        = 1'b0;
		wb_cyc       = 1'b0;
		wb_stb       = 1'b0;
		wb_we        = 1'b0;
		wb_adr       = 3'd0;
		wb_dat_w     = 32'd0;
		enc_a        = 1'b0;
		enc_b        = 1'b0;
		seed_val     = $urandom(32'h8d1f0e74);
		repeat (16) @(negedge clock_50);
		rst_n = 1'b1;

		// Reset state, well before the first window ends
		errs_before = err_total;
		check_eq("o_pwm after reset", 32'(pwm), 32'd0);
		check_eq("o_dir after reset", 32'(dir_out), 32'(wheel_pkg::DIR_BRAKE));
		for (a = 0; a <= 5; a++) begin
			wb_read(3'(a), rd);
			check_eq($sformatf("register %0d after reset", a), rd, 32'd0);
		end
		report_test("reset", errs_before);

		// Register access, settings cleared again before the first window
		errs_before = err_total;
		wb_write(wheel_pkg::REG_TARGET, 32'hFFFF_FFFF);
		wb_read(wheel_pkg::REG_TARGET, rd);
		check_eq("REG_TARGET readback", rd, 32'hFFFF_FFFF & TARGET_MASK);
		wb_write(wheel_pkg::REG_KP, 32'hABCD_1234);
		wb_read(wheel_pkg::REG_KP, rd);
		check_eq("REG_KP readback", rd, 32'hABCD_1234 & GAIN_MASK);
		wb_write(wheel_pkg::REG_KI, 32'h5A5A_5A96);
		wb_read(wheel_pkg::REG_KI, rd);
		check_eq("REG_KI readback", rd, 32'h5A5A_5A96 & GAIN_MASK);
		wb_write(wheel_pkg::REG_RPM, 32'h0000_1234);  // Read-only
		wb_read(wheel_pkg::REG_RPM, rd);
		check_eq("REG_RPM after write", rd, 32'd0);   // No window done yet, reset value
		wb_write(wheel_pkg::REG_TARGET, 32'd0);
		wb_write(wheel_pkg::REG_KP, 32'd0);
		wb_write(wheel_pkg::REG_KI, 32'd0);
		report_test("register access", errs_before);

		fd = $fopen("tb/wheel_golden.txt", "r");
		if (fd == 0) begin
			abort_run("Could not open the golden vector file tb/wheel_golden.txt");
		end else begin
			vec_idx = 0;
			while (!$feof(fd)) begin
				line   = "";
				n_read = $fgets(line, fd);
				if (n_read > 0 && line.getc(0) != "#") begin
					n_read = $sscanf(line, "%h %h %h %h %h %h %h %h %h", f_target, f_kp,
					                 f_ki, f_edges, f_dir, f_rpm, f_w, f_duty, f_odir);
					if (n_read == 9) begin
						vec_idx++;
						run_vector(vec_idx, f_target, f_kp, f_ki, f_edges, f_dir,
						           f_rpm, f_w, f_duty, f_odir);
					end
				end
			end
			$fclose(fd);
			if (vec_idx == 0) begin
				$display("No golden vectors were found in the data file");
				err_total++;
			end
			finish_run();
		end
	end

endmodule

// ==== wheel_controller.f ====
design/wheel_pkg.sv
design/wb_wheel_regs.sv
design/quad_decode.sv
design/speed_pi_exec.sv
design/pwm_result.sv
design/wheel_controller.sv
tb/tb_wheel_controller.sv

// ==== tb/wheel_golden.txt ====
# target kp ki edges dir | exp_rpm exp_w exp_duty exp_odir (all hex)
# dir 0 puts A ahead of B, 1 puts B ahead; exp_odir 0 brake, 1 fwd, 2 rev
# Each line runs one idle window then one window with the given edges
00A00 20 00 0A 0 02FB2 00507 5F 1
10A00 20 00 1E 1 08F16 10F17 00 2
01400 40 00 05 0 017D9 00283 FF 1
00500 00 10 08 0 02628 00406 39 1
00500 00 10 04 1 01314 00203 85 1
00000 10 10 06 0 01C9E 00304 4C 0
10000 00 30 14 1 05F64 10A0F 00 0
01900 10 F0 02 0 0098A 00101 FF 1
00000 FF 00 35 1 0FCC9 01AA9 43 0
